/* project.f */
rtl/mem_pipe_pkg.sv
rtl/exec_stage.sv
rtl/mem_stage1.sv
rtl/data_ram.sv
rtl/mem_stage2.sv
rtl/mem_pipe_top.sv
test/mem_pipe_tb.sv

/* rtl/data_ram.sv */
// ########################################
// data memory: word array, registered
// read-first port, per-byte write enables
// ########################################

`default_nettype none

module data_ram #(
    parameter int ADDR_WIDTH = 8
) (
    input  wire logic                  clk,
    input  mem_pipe_pkg::word_t        raddr,
    input  wire logic                  we,
    input  wire logic [3:0]            be,
    input  wire logic [ADDR_WIDTH-1:0] waddr,
    input  mem_pipe_pkg::word_t        wdata,
    output mem_pipe_pkg::word_t        rdata
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    mem_pipe_pkg::word_t   mem [DEPTH];
    logic [ADDR_WIDTH-1:0] ridx;

    assign ridx = raddr[ADDR_WIDTH+1:2];    // byte address to word index

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // read sees the contents before a same-edge write
    always_ff @(posedge clk) begin
        rdata <= mem[ridx];
        if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    mem[waddr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/exec_stage.sv */
// ########################################
// execute stage: input register, address /
// alu adder, branch compare and target
// ########################################

`default_nettype none

module exec_stage (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  stall,
    input  wire logic                  squash,

    input  wire logic                  in_valid,
    input  mem_pipe_pkg::op_t          in_op,
    input  mem_pipe_pkg::size_t        in_size,
    input  wire logic                  in_signed,
    input  mem_pipe_pkg::word_t        in_pc,
    input  mem_pipe_pkg::word_t        in_rs1_val,
    input  mem_pipe_pkg::word_t        in_rs2_val,
    input  mem_pipe_pkg::word_t        in_imm,
    input  mem_pipe_pkg::reg_idx_t     in_rd_idx,

    output logic                       e_valid,
    output mem_pipe_pkg::op_t          e_op,
    output mem_pipe_pkg::size_t        e_size,
    output logic                       e_signed,
    output mem_pipe_pkg::reg_idx_t     e_rd_idx,
    output mem_pipe_pkg::word_t        e_result,
    output mem_pipe_pkg::word_t        e_rs2_val,
    output mem_pipe_pkg::word_t        e_target,
    output logic                       e_branch
);

    logic                   valid_q;
    mem_pipe_pkg::op_t      op_q;
    mem_pipe_pkg::size_t    size_q;
    logic                   signed_q;
    mem_pipe_pkg::word_t    pc_q;
    mem_pipe_pkg::word_t    rs1_q;
    mem_pipe_pkg::word_t    rs2_q;
    mem_pipe_pkg::word_t    imm_q;
    mem_pipe_pkg::reg_idx_t rd_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= in_valid;
        end
    end

    // payload, held with the valid
    always_ff @(posedge clk) begin
        if (!stall) begin
            op_q     <= in_op;
            size_q   <= in_size;
            signed_q <= in_signed;
            pc_q     <= in_pc;
            rs1_q    <= in_rs1_val;
            rs2_q    <= in_rs2_val;
            imm_q    <= in_imm;
            rd_q     <= in_rd_idx;
        end
    end

    // a taken branch ahead kills the held op, unless the pipe is frozen
    assign e_valid = valid_q && (stall || !squash);

    assign e_op      = op_q;
    assign e_size    = size_q;
    assign e_signed  = signed_q;
    assign e_rd_idx  = rd_q;
    assign e_rs2_val = rs2_q;

    assign e_result = rs1_q + imm_q;    // alu sum and load/store address
    assign e_target = pc_q + imm_q;

    assign e_branch = (op_q == mem_pipe_pkg::OP_BEQ) && (rs1_q == rs2_q);

endmodule

`default_nettype wire

/* rtl/mem_pipe_pkg.sv */
// ########################################
// shared types for the load/store pipeline
// word width, operation codes, access sizes
// ########################################

`default_nettype none

package mem_pipe_pkg;

    // data and address width
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;    // values, addresses, pc
    typedef logic [4:0]      reg_idx_t;

    // operation codes
    typedef enum logic [1:0] {
        OP_ALU   = 2'd0,    // rd = rs1 + imm
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2,
        OP_BEQ   = 2'd3     // taken when rs1 == rs2
    } op_t;

    // access sizes, 2'd3 unused
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2
    } size_t;

endpackage

`default_nettype wire

/* rtl/mem_pipe_top.sv */
// ########################################
// pipeline top: execute, memory-1, data
// ram and memory-2 stages wired together
// ########################################

`default_nettype none

module mem_pipe_top #(
    parameter int ADDR_WIDTH = 8    // ram word address bits
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,

    input  wire logic                  in_valid,
    input  mem_pipe_pkg::op_t          in_op,
    input  mem_pipe_pkg::size_t        in_size,
    input  wire logic                  in_signed,
    input  mem_pipe_pkg::word_t        in_pc,
    input  mem_pipe_pkg::word_t        in_rs1_val,
    input  mem_pipe_pkg::word_t        in_rs2_val,
    input  mem_pipe_pkg::word_t        in_imm,
    input  mem_pipe_pkg::reg_idx_t     in_rd_idx,

    input  wire logic                  stall,
    input  wire logic                  flush,

    output logic                       wb_valid,
    output logic                       wb_we,
    output mem_pipe_pkg::reg_idx_t     wb_rd_idx,
    output mem_pipe_pkg::word_t        wb_data,

    output logic                       branch_taken,
    output mem_pipe_pkg::word_t        branch_target,

    output logic                       fwd_we,
    output mem_pipe_pkg::reg_idx_t     fwd_rd_idx,
    output mem_pipe_pkg::word_t        fwd_val,
    output logic                       fwd_val_avail
);

    // execute to memory-1
    logic                   e_valid;
    mem_pipe_pkg::op_t      e_op;
    mem_pipe_pkg::size_t    e_size;
    logic                   e_signed;
    mem_pipe_pkg::reg_idx_t e_rd_idx;
    mem_pipe_pkg::word_t    e_result;
    mem_pipe_pkg::word_t    e_rs2_val;
    mem_pipe_pkg::word_t    e_target;
    logic                   e_branch;

    // memory-1 to memory-2
    logic                   m1_valid;
    mem_pipe_pkg::op_t      m1_op;
    mem_pipe_pkg::size_t    m1_size;
    logic                   m1_signed;
    mem_pipe_pkg::reg_idx_t m1_rd_idx;
    mem_pipe_pkg::word_t    m1_result;

    // ram ports
    logic                   ram_we;
    logic [3:0]             ram_be;
    logic [ADDR_WIDTH-1:0]  ram_waddr;
    mem_pipe_pkg::word_t    ram_wdata;
    mem_pipe_pkg::word_t    ram_rdata;

    exec_stage u_exec (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .squash     (branch_taken),     // kill the op behind a taken branch
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_size    (in_size),
        .in_signed  (in_signed),
        .in_pc      (in_pc),
        .in_rs1_val (in_rs1_val),
        .in_rs2_val (in_rs2_val),
        .in_imm     (in_imm),
        .in_rd_idx  (in_rd_idx),
        .e_valid    (e_valid),
        .e_op       (e_op),
        .e_size     (e_size),
        .e_signed   (e_signed),
        .e_rd_idx   (e_rd_idx),
        .e_result   (e_result),
        .e_rs2_val  (e_rs2_val),
        .e_target   (e_target),
        .e_branch   (e_branch)
    );

    mem_stage1 #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_mem1 (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .flush         (flush),
        .e_valid       (e_valid),
        .e_op          (e_op),
        .e_size        (e_size),
        .e_signed      (e_signed),
        .e_rd_idx      (e_rd_idx),
        .e_result      (e_result),
        .e_rs2_val     (e_rs2_val),
        .e_target      (e_target),
        .e_branch      (e_branch),
        .m1_valid      (m1_valid),
        .m1_op         (m1_op),
        .m1_size       (m1_size),
        .m1_signed     (m1_signed),
        .m1_rd_idx     (m1_rd_idx),
        .m1_result     (m1_result),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .ram_we        (ram_we),
        .ram_be        (ram_be),
        .ram_waddr     (ram_waddr),
        .ram_wdata     (ram_wdata),
        .fwd_we        (fwd_we),
        .fwd_rd_idx    (fwd_rd_idx),
        .fwd_val       (fwd_val),
        .fwd_val_avail (fwd_val_avail)
    );

    // read address comes straight from execute, one cycle early
    data_ram #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_ram (
        .clk   (clk),
        .raddr (e_result),
        .we    (ram_we),
        .be    (ram_be),
        .waddr (ram_waddr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    mem_stage2 u_mem2 (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .m1_valid  (m1_valid),
        .m1_op     (m1_op),
        .m1_size   (m1_size),
        .m1_signed (m1_signed),
        .m1_rd_idx (m1_rd_idx),
        .m1_result (m1_result),
        .ram_rdata (ram_rdata),
        .wb_valid  (wb_valid),
        .wb_we     (wb_we),
        .wb_rd_idx (wb_rd_idx),
        .wb_data   (wb_data)
    );

endmodule

`default_nettype wire

/* rtl/mem_stage1.sv */
// ########################################
// memory-1 stage: stage register, store
// issue, branch redirect, forwarding view
// ########################################

`default_nettype none

module mem_stage1 #(
    parameter int ADDR_WIDTH = 8
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  stall,
    input  wire logic                  flush,

    input  wire logic                  e_valid,
    input  mem_pipe_pkg::op_t          e_op,
    input  mem_pipe_pkg::size_t        e_size,
    input  wire logic                  e_signed,
    input  mem_pipe_pkg::reg_idx_t     e_rd_idx,
    input  mem_pipe_pkg::word_t        e_result,
    input  mem_pipe_pkg::word_t        e_rs2_val,
    input  mem_pipe_pkg::word_t        e_target,
    input  wire logic                  e_branch,

    output logic                       m1_valid,
    output mem_pipe_pkg::op_t          m1_op,
    output mem_pipe_pkg::size_t        m1_size,
    output logic                       m1_signed,
    output mem_pipe_pkg::reg_idx_t     m1_rd_idx,
    output mem_pipe_pkg::word_t        m1_result,

    output logic                       branch_taken,
    output mem_pipe_pkg::word_t        branch_target,

    output logic                       ram_we,
    output logic [3:0]                 ram_be,
    output logic [ADDR_WIDTH-1:0]      ram_waddr,
    output mem_pipe_pkg::word_t        ram_wdata,

    output logic                       fwd_we,
    output mem_pipe_pkg::reg_idx_t     fwd_rd_idx,
    output mem_pipe_pkg::word_t        fwd_val,
    output logic                       fwd_val_avail
);

    logic                   valid_q;
    mem_pipe_pkg::op_t      op_q;
    mem_pipe_pkg::size_t    size_q;
    logic                   signed_q;
    mem_pipe_pkg::reg_idx_t rd_q;
    mem_pipe_pkg::word_t    result_q;
    mem_pipe_pkg::word_t    rs2_q;
    mem_pipe_pkg::word_t    target_q;
    logic                   branch_q;
    logic                   writes_rd;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= e_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            op_q     <= e_op;
            size_q   <= e_size;
            signed_q <= e_signed;
            rd_q     <= e_rd_idx;
            result_q <= e_result;
            rs2_q    <= e_rs2_val;
            target_q <= e_target;
            branch_q <= e_branch;
        end
    end

    // op leaves this cycle only if neither flushed nor frozen
    assign m1_valid  = valid_q && !flush && !stall;
    assign m1_op     = op_q;
    assign m1_size   = size_q;
    assign m1_signed = signed_q;
    assign m1_rd_idx = rd_q;
    assign m1_result = result_q;

    assign branch_taken  = valid_q && branch_q;
    assign branch_target = target_q;

    assign ram_we    = m1_valid && (op_q == mem_pipe_pkg::OP_STORE);
    assign ram_waddr = result_q[ADDR_WIDTH+1:2];    // word index

    // byte lanes from size and low address bits
    always_comb begin
        case (size_q)
            mem_pipe_pkg::SIZE_B: begin
                ram_be    = 4'b0001 << result_q[1:0];
                ram_wdata = rs2_q << {result_q[1:0], 3'b000};
            end
            mem_pipe_pkg::SIZE_H: begin
                ram_be    = 4'b0011 << {result_q[1], 1'b0};
                ram_wdata = rs2_q << {result_q[1], 4'b0000};
            end
            default: begin
                ram_be    = 4'b1111;
                ram_wdata = rs2_q;
            end
        endcase
    end

    assign writes_rd = (op_q == mem_pipe_pkg::OP_ALU) || (op_q == mem_pipe_pkg::OP_LOAD);

    assign fwd_we        = valid_q && writes_rd && (rd_q != '0);
    assign fwd_rd_idx    = rd_q;
    assign fwd_val       = result_q;
    assign fwd_val_avail = valid_q && (op_q == mem_pipe_pkg::OP_ALU);   // load data not here yet

endmodule

`default_nettype wire

/* rtl/mem_stage2.sv */
// ########################################
// memory-2 stage: stage register, load
// lane select and extension, writeback
// ########################################

`default_nettype none

module mem_stage2 (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  stall,

    input  wire logic                  m1_valid,
    input  mem_pipe_pkg::op_t          m1_op,
    input  mem_pipe_pkg::size_t        m1_size,
    input  wire logic                  m1_signed,
    input  mem_pipe_pkg::reg_idx_t     m1_rd_idx,
    input  mem_pipe_pkg::word_t        m1_result,
    input  mem_pipe_pkg::word_t        ram_rdata,

    output logic                       wb_valid,
    output logic                       wb_we,
    output mem_pipe_pkg::reg_idx_t     wb_rd_idx,
    output mem_pipe_pkg::word_t        wb_data
);

    logic                   valid_q;
    mem_pipe_pkg::op_t      op_q;
    mem_pipe_pkg::size_t    size_q;
    logic                   signed_q;
    mem_pipe_pkg::reg_idx_t rd_q;
    mem_pipe_pkg::word_t    result_q;
    mem_pipe_pkg::word_t    rdata_q;
    logic                   hold_vld;
    mem_pipe_pkg::word_t    rdata_hold;
    mem_pipe_pkg::word_t    rdata_in;
    mem_pipe_pkg::word_t    lane;
    mem_pipe_pkg::word_t    load_val;

    // the ram keeps reading while frozen, so keep the word that belongs to m1
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_vld <= 1'b0;
        end else if (!stall) begin
            hold_vld <= 1'b0;
        end else if (!hold_vld) begin
            hold_vld <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (stall && !hold_vld) begin
            rdata_hold <= ram_rdata;    // first frozen edge only
        end
    end

    assign rdata_in = hold_vld ? rdata_hold : ram_rdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= m1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            op_q     <= m1_op;
            size_q   <= m1_size;
            signed_q <= m1_signed;
            rd_q     <= m1_rd_idx;
            result_q <= m1_result;
            rdata_q  <= rdata_in;
        end
    end

    assign lane = rdata_q >> {result_q[1:0], 3'b000};   // addressed byte to bit 0

    always_comb begin
        case (size_q)
            mem_pipe_pkg::SIZE_B: load_val = {{24{signed_q & lane[7]}}, lane[7:0]};
            mem_pipe_pkg::SIZE_H: load_val = {{16{signed_q & lane[15]}}, lane[15:0]};
            default:              load_val = rdata_q;
        endcase
    end

    assign wb_valid  = valid_q && !stall;
    assign wb_rd_idx = rd_q;
    assign wb_data   = (op_q == mem_pipe_pkg::OP_LOAD) ? load_val : result_q;

    // stores and branches retire without a register write
    assign wb_we = wb_valid && (rd_q != '0) &&
                   ((op_q == mem_pipe_pkg::OP_ALU) || (op_q == mem_pipe_pkg::OP_LOAD));

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build and run the pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module mem_pipe_tb -o mem_pipe_sim \
    && ./obj_dir/mem_pipe_sim | tee sim.log
grep -q "^NO ERRORS$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* test/mem_pipe_tb.sv */
// ########################################
// testbench for the load/store pipeline:
// stimulus table, pipeline and memory
// model, output checks, cycle limit
// ########################################

`default_nettype none

module mem_pipe_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 16;
    localparam int DRAIN_CYCLES = 20;

    localparam mem_pipe_pkg::op_t   ALU = mem_pipe_pkg::OP_ALU;
    localparam mem_pipe_pkg::op_t   LD  = mem_pipe_pkg::OP_LOAD;
    localparam mem_pipe_pkg::op_t   ST  = mem_pipe_pkg::OP_STORE;
    localparam mem_pipe_pkg::op_t   BEQ = mem_pipe_pkg::OP_BEQ;
    localparam mem_pipe_pkg::size_t SB  = mem_pipe_pkg::SIZE_B;
    localparam mem_pipe_pkg::size_t SH  = mem_pipe_pkg::SIZE_H;
    localparam mem_pipe_pkg::size_t SW  = mem_pipe_pkg::SIZE_W;

    typedef struct packed {
        logic                   valid;
        mem_pipe_pkg::op_t      op;
        mem_pipe_pkg::size_t    size;
        logic                   sgn;
        mem_pipe_pkg::word_t    pc;
        mem_pipe_pkg::word_t    rs1;
        mem_pipe_pkg::word_t    rs2;
        mem_pipe_pkg::word_t    imm;
        mem_pipe_pkg::reg_idx_t rd;
        mem_pipe_pkg::word_t    rdata;  // word read for a load
    } slot_t;

    typedef struct packed {
        logic [3:0] grp;
        logic       stall;
        logic       flush;
        slot_t      op;
    } row_t;

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid;
    mem_pipe_pkg::op_t      in_op;
    mem_pipe_pkg::size_t    in_size;
    logic                   in_signed;
    mem_pipe_pkg::word_t    in_pc;
    mem_pipe_pkg::word_t    in_rs1_val;
    mem_pipe_pkg::word_t    in_rs2_val;
    mem_pipe_pkg::word_t    in_imm;
    mem_pipe_pkg::reg_idx_t in_rd_idx;
    logic                   stall;
    logic                   flush;
    logic                   wb_valid;
    logic                   wb_we;
    mem_pipe_pkg::reg_idx_t wb_rd_idx;
    mem_pipe_pkg::word_t    wb_data;
    logic                   branch_taken;
    mem_pipe_pkg::word_t    branch_target;
    logic                   fwd_we;
    mem_pipe_pkg::reg_idx_t fwd_rd_idx;
    mem_pipe_pkg::word_t    fwd_val;
    logic                   fwd_val_avail;

    row_t                tbl[$];
    slot_t               e_s;     // model of exec, memory-1, memory-2
    slot_t               m1_s;
    slot_t               m2_s;
    mem_pipe_pkg::word_t shadow [256];
    mem_pipe_pkg::word_t next_pc;
    int                  errors;
    int                  checks;
    int                  retired;
    int                  cycles;
    int                  limit;

    string grp_name [6] = '{"alu", "load/store", "branch", "flush", "stall", "drain"};

    mem_pipe_top #(
        .ADDR_WIDTH (8)
    ) DUT (
        .clk (clk), .rst_n (rst_n),
        .in_valid (in_valid), .in_op (in_op), .in_size (in_size), .in_signed (in_signed),
        .in_pc (in_pc), .in_rs1_val (in_rs1_val), .in_rs2_val (in_rs2_val),
        .in_imm (in_imm), .in_rd_idx (in_rd_idx), .stall (stall), .flush (flush),
        .wb_valid (wb_valid), .wb_we (wb_we), .wb_rd_idx (wb_rd_idx), .wb_data (wb_data),
        .branch_taken (branch_taken), .branch_target (branch_target),
        .fwd_we (fwd_we), .fwd_rd_idx (fwd_rd_idx), .fwd_val (fwd_val),
        .fwd_val_avail (fwd_val_avail)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // guard against a run that never ends
    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic add_row(input logic [3:0] g, input logic v, input mem_pipe_pkg::op_t op,
                           input mem_pipe_pkg::size_t sz, input logic sg,
                           input mem_pipe_pkg::word_t rs1, input mem_pipe_pkg::word_t rs2,
                           input mem_pipe_pkg::word_t imm, input mem_pipe_pkg::reg_idx_t rd,
                           input logic st, input logic fl);
        row_t r;
        r.grp = g;
        r.stall = st;
        r.flush = fl;
        r.op = '{v, op, sz, sg, next_pc, rs1, rs2, imm, rd, 32'h0};
        next_pc = next_pc + 32'd4;
        tbl.push_back(r);
    endtask

    task automatic add_idle(input logic [3:0] g, input logic st, input logic fl);
        add_row(g, 1'b0, ALU, SW, 1'b0, 32'h0, 32'h0, 32'h0, 5'd0, st, fl);
    endtask

    task automatic build_table();
        add_row(4'd0, 1'b1, ALU, SW, 1'b0, 32'd5, 32'h0, 32'd7, 5'd1, 1'b0, 1'b0);
        add_row(4'd0, 1'b1, ALU, SW, 1'b0, $urandom, 32'h0, $urandom, 5'd2, 1'b0, 1'b0);
        add_row(4'd0, 1'b1, ALU, SW, 1'b0, 32'd3, 32'h0, 32'd4, 5'd0, 1'b0, 1'b0);  // rd zero
        add_row(4'd0, 1'b1, ALU, SW, 1'b0, $urandom, 32'h0, 32'hfffffff0, 5'd31, 1'b0, 1'b0);
        add_row(4'd1, 1'b1, ST, SW, 1'b0, 32'h40, 32'h8badf00d, 32'h0, 5'd0, 1'b0, 1'b0);
        add_row(4'd1, 1'b1, LD, SW, 1'b0, 32'h3c, 32'h0, 32'h4, 5'd10, 1'b0, 1'b0);  // old word
        add_row(4'd1, 1'b1, LD, SW, 1'b0, 32'h40, 32'h0, 32'h0, 5'd11, 1'b0, 1'b0);
        add_row(4'd1, 1'b1, LD, SB, 1'b1, 32'h43, 32'h0, 32'h0, 5'd12, 1'b0, 1'b0);
        add_row(4'd1, 1'b1, LD, SB, 1'b0, 32'h41, 32'h0, 32'h0, 5'd13, 1'b0, 1'b0);
        add_row(4'd1, 1'b1, LD, SH, 1'b1, 32'h42, 32'h0, 32'h0, 5'd14, 1'b0, 1'b0);
        add_row(4'd1, 1'b1, LD, SH, 1'b0, 32'h40, 32'h0, 32'h0, 5'd15, 1'b0, 1'b0);
        add_row(4'd1, 1'b1, ST, SB, 1'b0, 32'h45, 32'h000000a5, 32'h0, 5'd0, 1'b0, 1'b0);
        add_row(4'd1, 1'b1, ST, SH, 1'b0, 32'h4a, $urandom, 32'h0, 5'd0, 1'b0, 1'b0);
        add_idle(4'd1, 1'b0, 1'b0);
        add_row(4'd1, 1'b1, LD, SW, 1'b0, 32'h44, 32'h0, 32'h0, 5'd16, 1'b0, 1'b0);
        add_row(4'd1, 1'b1, LD, SW, 1'b0, 32'h48, 32'h0, 32'h0, 5'd17, 1'b0, 1'b0);
        add_row(4'd1, 1'b1, LD, SB, 1'b1, 32'h45, 32'h0, 32'h0, 5'd18, 1'b0, 1'b0);
        add_row(4'd1, 1'b1, LD, SH, 1'b1, 32'h4a, 32'h0, 32'h0, 5'd0, 1'b0, 1'b0);
        add_row(4'd2, 1'b1, BEQ, SW, 1'b0, 32'd9, 32'd9, 32'h20, 5'd0, 1'b0, 1'b0);
        add_row(4'd2, 1'b1, ALU, SW, 1'b0, 32'd1, 32'h0, 32'd1, 5'd3, 1'b0, 1'b0);  // squashed
        add_row(4'd2, 1'b1, ALU, SW, 1'b0, 32'd2, 32'h0, 32'd2, 5'd4, 1'b0, 1'b0);
        add_row(4'd2, 1'b1, BEQ, SW, 1'b0, 32'd1, 32'd2, 32'h40, 5'd0, 1'b0, 1'b0);
        add_row(4'd2, 1'b1, ALU, SW, 1'b0, 32'd3, 32'h0, 32'd3, 5'd5, 1'b0, 1'b0);
        add_idle(4'd2, 1'b0, 1'b0);
        add_row(4'd3, 1'b1, ST, SW, 1'b0, 32'h50, 32'hdeadbeef, 32'h0, 5'd0, 1'b0, 1'b0);
        add_row(4'd3, 1'b1, ALU, SW, 1'b0, 32'd1, 32'h0, 32'd1, 5'd6, 1'b0, 1'b0);
        add_row(4'd3, 1'b1, ALU, SW, 1'b0, 32'd7, 32'h0, 32'd7, 5'd7, 1'b0, 1'b1);  // kills store
        add_row(4'd3, 1'b1, ALU, SW, 1'b0, 32'd2, 32'h0, 32'd2, 5'd8, 1'b0, 1'b1);  // kills rd 6
        add_idle(4'd3, 1'b0, 1'b0);
        add_idle(4'd3, 1'b0, 1'b0);
        add_row(4'd3, 1'b1, LD, SW, 1'b0, 32'h50, 32'h0, 32'h0, 5'd9, 1'b0, 1'b0);
        add_idle(4'd3, 1'b0, 1'b0);
        add_row(4'd4, 1'b1, ALU, SW, 1'b0, $urandom, 32'h0, 32'h0, 5'd20, 1'b0, 1'b0);
        add_row(4'd4, 1'b1, ST, SW, 1'b0, 32'h60, $urandom, 32'h0, 5'd0, 1'b0, 1'b0);
        add_row(4'd4, 1'b1, LD, SW, 1'b0, 32'h60, 32'h0, 32'h0, 5'd21, 1'b0, 1'b0);
        add_idle(4'd4, 1'b1, 1'b0);     // store frozen in memory-1
        add_idle(4'd4, 1'b1, 1'b0);
        add_idle(4'd4, 1'b1, 1'b0);
        add_idle(4'd4, 1'b0, 1'b0);
        add_row(4'd4, 1'b1, LD, SW, 1'b0, 32'h60, 32'h0, 32'h0, 5'd22, 1'b0, 1'b0);
        add_row(4'd4, 1'b1, ALU, SW, 1'b0, 32'd4, 32'h0, 32'd4, 5'd23, 1'b0, 1'b0);
        add_idle(4'd4, 1'b1, 1'b0);     // load frozen in memory-1
        add_idle(4'd4, 1'b1, 1'b0);
        add_idle(4'd4, 1'b0, 1'b0);
        repeat (6) add_idle(4'd5, 1'b0, 1'b0);
    endtask

    function automatic mem_pipe_pkg::word_t load_result(input slot_t s);
        mem_pipe_pkg::word_t a;
        logic [7:0]          b;
        logic [15:0]         h;
        a = s.rs1 + s.imm;
        b = s.rdata[8*a[1:0] +: 8];
        h = s.rdata[16*a[1] +: 16];
        case (s.size)
            SB:      return s.sgn ? {{24{b[7]}}, b} : {24'h0, b};
            SH:      return s.sgn ? {{16{h[15]}}, h} : {16'h0, h};
            default: return s.rdata;
        endcase
    endfunction

    task automatic apply_store(input slot_t s);
        mem_pipe_pkg::word_t a;
        a = s.rs1 + s.imm;
        case (s.size)
            SB:      shadow[a[9:2]][8*a[1:0] +: 8] = s.rs2[7:0];
            SH:      shadow[a[9:2]][16*a[1] +: 16] = s.rs2[15:0];
            default: shadow[a[9:2]] = s.rs2;
        endcase
    endtask

    // one clock edge of the model, using the inputs of the cycle just ended
    task automatic advance_model();
        slot_t               nxt_m1;
        slot_t               nxt_m2;
        logic                taken;
        mem_pipe_pkg::word_t a;
        if (!rst_n) begin
            e_s.valid = 1'b0;
            m1_s.valid = 1'b0;
            m2_s.valid = 1'b0;
        end else if (!stall) begin
            taken = m1_s.valid && m1_s.op == BEQ && m1_s.rs1 == m1_s.rs2;
            nxt_m2 = m1_s;
            nxt_m2.valid = m1_s.valid && !flush;
            nxt_m1 = e_s;
            nxt_m1.valid = e_s.valid && !taken;
            a = e_s.rs1 + e_s.imm;
            nxt_m1.rdata = shadow[a[9:2]];  // read before this edge's write
            if (m1_s.valid && !flush && m1_s.op == ST) apply_store(m1_s);
            m2_s = nxt_m2;
            m1_s = nxt_m1;
            e_s = '{in_valid, in_op, in_size, in_signed, in_pc, in_rs1_val, in_rs2_val,
                    in_imm, in_rd_idx, 32'h0};
        end
    endtask

    task automatic drive_row(input row_t r);
        in_valid   = r.op.valid;
        in_op      = r.op.op;
        in_size    = r.op.size;
        in_signed  = r.op.sgn;
        in_pc      = r.op.pc;
        in_rs1_val = r.op.rs1;
        in_rs2_val = r.op.rs2;
        in_imm     = r.op.imm;
        in_rd_idx  = r.op.rd;
        stall      = r.stall;
        flush      = r.flush;
    endtask

    task automatic check_outputs();
        logic                exp_wbv;
        logic                exp_wbwe;
        logic                exp_br;
        logic                exp_fwe;
        logic                exp_avail;
        mem_pipe_pkg::word_t exp_data;
        exp_wbv   = m2_s.valid && !stall;
        exp_wbwe  = exp_wbv && m2_s.rd != 5'd0 && (m2_s.op == ALU || m2_s.op == LD);
        exp_data  = (m2_s.op == LD) ? load_result(m2_s) : m2_s.rs1 + m2_s.imm;
        exp_br    = m1_s.valid && m1_s.op == BEQ && m1_s.rs1 == m1_s.rs2;
        exp_fwe   = m1_s.valid && m1_s.rd != 5'd0 && (m1_s.op == ALU || m1_s.op == LD);
        exp_avail = m1_s.valid && m1_s.op == ALU;
        checks++;
        assert (wb_valid === exp_wbv && wb_we === exp_wbwe) else begin
            $display("Error at %0t: wb_valid/wb_we %b%b, expected %b%b", $time,
                     wb_valid, wb_we, exp_wbv, exp_wbwe);
            errors++;
        end
        if (exp_wbwe) begin
            retired++;
            assert (wb_rd_idx === m2_s.rd && wb_data === exp_data) else begin
                $display("Error at %0t: writeback x%0d=%h, expected x%0d=%h", $time,
                         wb_rd_idx, wb_data, m2_s.rd, exp_data);
                errors++;
            end
        end
        assert (branch_taken === exp_br) else begin
            $display("Error at %0t: branch_taken %b, expected %b", $time, branch_taken, exp_br);
            errors++;
        end
        if (exp_br) begin
            assert (branch_target === m1_s.pc + m1_s.imm) else begin
                $display("Error at %0t: branch_target %h, expected %h", $time,
                         branch_target, m1_s.pc + m1_s.imm);
                errors++;
            end
        end
        assert (fwd_we === exp_fwe && fwd_val_avail === exp_avail) else begin
            $display("Error at %0t: fwd_we/fwd_val_avail %b%b, expected %b%b", $time,
                     fwd_we, fwd_val_avail, exp_fwe, exp_avail);
            errors++;
        end
        if (exp_fwe) begin
            assert (fwd_rd_idx === m1_s.rd) else begin
                $display("Error at %0t: fwd_rd_idx %0d, expected %0d", $time,
                         fwd_rd_idx, m1_s.rd);
                errors++;
            end
        end
        if (exp_avail) begin
            assert (fwd_val === m1_s.rs1 + m1_s.imm) else begin
                $display("Error at %0t: fwd_val %h, expected %h", $time,
                         fwd_val, m1_s.rs1 + m1_s.imm);
                errors++;
            end
        end
    endtask

    initial begin
        logic [3:0]  cur_grp;
        int          grp_err;
        void'($urandom(32'hb15a0861));  // one seed for the whole run
        rst_n = 1'b0;
        drive_row('0);
        errors = 0;
        checks = 0;
        retired = 0;
        cycles = 0;
        limit = 1000;
        next_pc = 32'h100;
        e_s = '0;
        m1_s = '0;
        m2_s = '0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = '0;
        end
        build_table();
        limit = tbl.size() + RESET_CYCLES + DRAIN_CYCLES;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            advance_model();
        end
        #2 rst_n = 1'b1;
        cur_grp = tbl[0].grp;
        grp_err = 0;
        for (int i = 0; i < tbl.size(); i++) begin
            @(posedge clk);
            advance_model();
            if (tbl[i].grp != cur_grp) begin
                $display("test %s finished with %0d errors", grp_name[cur_grp], errors - grp_err);
                cur_grp = tbl[i].grp;
                grp_err = errors;
            end
            #2 drive_row(tbl[i]);
            @(negedge clk);
            check_outputs();
        end
        $display("test %s finished with %0d errors", grp_name[cur_grp], errors - grp_err);
        $display("%0d cycles checked, %0d register writes, %0d errors", checks, retired, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
